/* Makefile */
# Verilator build for the pipelined DES core

VERILATOR ?= verilator
TOP       ?= tbDesCore
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+.
desPkg.sv
desInputStage.sv
desRound.sv
desOutputStage.sv
desCore.sv
tbDesCore.sv

/* tbDesCore.sv */
`default_nettype none
`timescale 1ns/100ps

module tbDesCore;
	import desPkg::*;

	localparam int LATENCY    = 18;
	localparam int WAIT_LIMIT = 100;
	localparam int NUM_TRIPS  = 20;
	localparam int NUM_STREAM = 12;

	// known-answer pairs
	localparam logic [BLOCK_W-1:0] KA1_KEY    = 64'h1334_5779_9BBC_DFF1;
	localparam logic [BLOCK_W-1:0] KA1_PLAIN  = 64'h0123_4567_89AB_CDEF;
	localparam logic [BLOCK_W-1:0] KA1_CIPHER = 64'h85E8_1354_0F0A_B405;
	localparam logic [BLOCK_W-1:0] KA2_KEY    = 64'h0E32_9232_EA6D_0D73;
	localparam logic [BLOCK_W-1:0] KA2_PLAIN  = 64'h8787_8787_8787_8787;
	localparam logic [BLOCK_W-1:0] KA2_CIPHER = 64'h0000_0000_0000_0000;

	logic               clk;
	logic               rst;
	logic               start;
	logic               dec;
	logic [BLOCK_W-1:0] keyIn;
	logic [BLOCK_W-1:0] textIn;
	wire                done;
	wire  [BLOCK_W-1:0] textOut;

	int mismatchCount;
	int failCount;

	logic [BLOCK_W-1:0] tripKey    [NUM_TRIPS];
	logic [BLOCK_W-1:0] tripText   [NUM_TRIPS];
	logic [BLOCK_W-1:0] tripCipher [NUM_TRIPS];

	logic [BLOCK_W-1:0] reqKey  [$];
	logic [BLOCK_W-1:0] reqText [$];
	logic [BLOCK_W-1:0] reqExp  [$];
	bit                 reqDec  [$];

	desCore DUT (
		.i_Clk    (clk),
		.i_Rst    (rst),
		.i_fStart (start),
		.i_fDec   (dec),
		.i_Key    (keyIn),
		.i_Text   (textIn),
		.o_fDone  (done),
		.o_Text   (textOut)
	);

	always #4 clk = ~clk;

	// ##############################
	// compare tasks
	// ##############################
	task automatic checkBlock(input logic [BLOCK_W-1:0] got, input logic [BLOCK_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			mismatchCount++;
			$display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkDone(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			mismatchCount++;
			$display("mismatch at %0t: %s done is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkLatency(input int got, input int exp, input string what);
		if (got != exp) begin
			mismatchCount++;
			$display("mismatch at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	// ##############################
	// helpers
	// ##############################
	task automatic applyReset();
		@(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b1;
	endtask

	// done shows at the 18th falling edge after the start was driven
	task automatic runBlock(input logic [BLOCK_W-1:0] key, input logic [BLOCK_W-1:0] text,
			input bit decrypt, output logic [BLOCK_W-1:0] result);
		int waited;
		@(negedge clk);
		start  = 1'b1;
		dec    = decrypt;
		keyIn  = key;
		textIn = text;
		@(negedge clk);
		start  = 1'b0;
		waited = 1;
		while (!done && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		result = textOut;
		if (!done) begin
			failCount++;
			$display("timeout at %0t: no done pulse arrived for a single block", $time);
		end else begin
			checkLatency(waited, LATENCY, "block latency");
			@(negedge clk);
			checkDone(done, 1'b0, "end of done pulse");
		end
	endtask

	task automatic queueRequest(input logic [BLOCK_W-1:0] key, input logic [BLOCK_W-1:0] text,
			input bit decrypt, input logic [BLOCK_W-1:0] exp);
		reqKey.push_back(key);
		reqText.push_back(text);
		reqDec.push_back(decrypt);
		reqExp.push_back(exp);
	endtask

	task automatic checkIdle(input int cycles, input string what);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			checkDone(done, 1'b0, what);
			checkBlock(textOut, '0, what);
		end
	endtask

	// ##############################
	// directed tests
	// ##############################
	task automatic testKnownEncrypt();
		logic [BLOCK_W-1:0] result;
		runBlock(KA1_KEY, KA1_PLAIN, 1'b0, result);
		checkBlock(result, KA1_CIPHER, "known encrypt 1");
		runBlock(KA2_KEY, KA2_PLAIN, 1'b0, result);
		checkBlock(result, KA2_CIPHER, "known encrypt 2");
	endtask

	task automatic testKnownDecrypt();
		logic [BLOCK_W-1:0] result;
		runBlock(KA1_KEY, KA1_CIPHER, 1'b1, result);
		checkBlock(result, KA1_PLAIN, "known decrypt 1");
		runBlock(KA2_KEY, KA2_CIPHER, 1'b1, result);
		checkBlock(result, KA2_PLAIN, "known decrypt 2");
	endtask

	task automatic testRoundTrip();
		logic [BLOCK_W-1:0] cipher;
		logic [BLOCK_W-1:0] plain;
		for (int i = 0; i < NUM_TRIPS; i++) begin
			tripKey[i]  = {$urandom, $urandom};
			tripText[i] = {$urandom, $urandom};
			runBlock(tripKey[i], tripText[i], 1'b0, cipher);
			tripCipher[i] = cipher;
			runBlock(tripKey[i], cipher, 1'b1, plain);
			checkBlock(plain, tripText[i], $sformatf("round trip %0d", i));
		end
	endtask

	task automatic testStreaming();
		int pick;
		int waited;
		queueRequest(KA1_KEY, KA1_PLAIN, 1'b0, KA1_CIPHER);
		queueRequest(KA2_KEY, KA2_CIPHER, 1'b1, KA2_PLAIN);
		// encrypt then decrypt of a stored round trip, back to back
		for (int j = 0; j < 4; j++) begin
			pick = int'($urandom % NUM_TRIPS);
			queueRequest(tripKey[pick], tripText[pick], 1'b0, tripCipher[pick]);
			queueRequest(tripKey[pick], tripCipher[pick], 1'b1, tripText[pick]);
		end
		queueRequest(KA1_KEY, KA1_CIPHER, 1'b1, KA1_PLAIN);
		queueRequest(KA2_KEY, KA2_PLAIN, 1'b0, KA2_CIPHER);

		// request k is driven at falling edge k
		for (int k = 0; k < NUM_STREAM; k++) begin
			@(negedge clk);
			checkDone(done, 1'b0, "stream still filling");
			start  = 1'b1;
			dec    = reqDec[k];
			keyIn  = reqKey[k];
			textIn = reqText[k];
		end
		@(negedge clk);
		start  = 1'b0;
		waited = NUM_STREAM;
		while (!done && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!done) begin
			failCount++;
			$display("timeout at %0t: the stream produced no done pulse", $time);
		end else begin
			checkLatency(waited, LATENCY, "first stream result latency");
			for (int k = 0; k < NUM_STREAM; k++) begin
				checkDone(done, 1'b1, $sformatf("stream done %0d", k));
				checkBlock(textOut, reqExp[k], $sformatf("stream result %0d", k));
				@(negedge clk);
			end
			checkDone(done, 1'b0, "after the stream");
		end
	endtask

	task automatic testResetInFlight();
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			start  = 1'b1;
			dec    = k[0];
			keyIn  = {$urandom, $urandom};
			textIn = {$urandom, $urandom};
		end
		@(negedge clk);
		start = 1'b0;
		repeat (5) @(negedge clk);
		applyReset();
		checkIdle(40, "after reset in flight");
	endtask

	initial begin
		clk           = 1'b0;
		rst           = 1'b0;
		start         = 1'b0;
		dec           = 1'b0;
		keyIn         = '0;
		textIn        = '0;
		mismatchCount = 0;
		failCount     = 0;
		void'($urandom(32'h5ac6_0af0));
		repeat (2) @(negedge clk);
		rst = 1'b1;

		checkIdle(40, "idle after reset");
		testKnownEncrypt();
		testKnownDecrypt();
		testRoundTrip();
		testStreaming();
		testResetInFlight();

		$display("mismatches: %0d, other failures: %0d", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* desCore.sv */
`default_nettype none
`timescale 1ns/100ps

module desCore (
	input  wire                         i_Clk,
	input  wire                         i_Rst,
	input  wire                         i_fStart,
	input  wire                         i_fDec,
	input  wire [desPkg::BLOCK_W-1:0]   i_Key,
	input  wire [desPkg::BLOCK_W-1:0]   i_Text,
	output wire                         o_fDone,
	output wire [desPkg::BLOCK_W-1:0]   o_Text
);
	import desPkg::*;

	// slot 0 is the input stage, slot k the output of round k
	roundState_t stageState [0:NUM_ROUNDS];

	desInputStage uInput (
		.i_Clk    (i_Clk),
		.i_Rst    (i_Rst),
		.i_fStart (i_fStart),
		.i_fDec   (i_fDec),
		.i_Key    (i_Key),
		.i_Text   (i_Text),
		.o_State  (stageState[0])
	);

	// ##############################
	// sixteen round stages
	// ##############################
	for (genvar k = 1; k <= NUM_ROUNDS; k++) begin : gRound
		desRound #(
			.ROUND_IDX (k)
		) uRound (
			.i_Clk   (i_Clk),
			.i_Rst   (i_Rst),
			.i_State (stageState[k-1]),
			.o_State (stageState[k])
		);
	end

	desOutputStage uOutput (
		.i_Clk   (i_Clk),
		.i_Rst   (i_Rst),
		.i_State (stageState[NUM_ROUNDS]),
		.o_fDone (o_fDone),
		.o_Text  (o_Text)
	);

endmodule

`default_nettype wire

/* desOutputStage.sv */
`default_nettype none
`timescale 1ns/100ps

module desOutputStage (
	input  wire                         i_Clk,
	input  wire                         i_Rst,
	input  wire desPkg::roundState_t    i_State,
	output logic                        o_fDone,
	output logic [desPkg::BLOCK_W-1:0]  o_Text
);
	import desPkg::*;

	// inverse of the initial permutation
	function automatic logic [BLOCK_W-1:0] invIpPerm(input logic [BLOCK_W-1:0] x);
		return {x[24], x[56], x[16], x[48], x[ 8], x[40], x[ 0], x[32],
				x[25], x[57], x[17], x[49], x[ 9], x[41], x[ 1], x[33],
				x[26], x[58], x[18], x[50], x[10], x[42], x[ 2], x[34],
				x[27], x[59], x[19], x[51], x[11], x[43], x[ 3], x[35],
				x[28], x[60], x[20], x[52], x[12], x[44], x[ 4], x[36],
				x[29], x[61], x[21], x[53], x[13], x[45], x[ 5], x[37],
				x[30], x[62], x[22], x[54], x[14], x[46], x[ 6], x[38],
				x[31], x[63], x[23], x[55], x[15], x[47], x[ 7], x[39]};
	endfunction

	logic [BLOCK_W-1:0] resultText;

	// halves swap back after the last round
	assign resultText = invIpPerm({i_State.r, i_State.l});

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			o_fDone <= 1'b0;
			o_Text  <= '0;
		end else begin
			o_fDone <= i_State.valid;
			o_Text  <= i_State.valid ? resultText : '0;
		end
	end

	// the last round hands over idle slots with no key material
	idleSlotNoKey: assert property (
		@(posedge i_Clk) disable iff (!i_Rst)
		!i_State.valid |-> (i_State.c == '0 && i_State.d == '0)
	);

endmodule

`default_nettype wire

/* desRound.sv */
`default_nettype none
`timescale 1ns/100ps

module desRound #(
	parameter int ROUND_IDX = 1
) (
	input  wire                         i_Clk,
	input  wire                         i_Rst,
	input  wire desPkg::roundState_t    i_State,
	output desPkg::roundState_t         o_State
);
	import desPkg::*;

	// encryption rotates left before PC2, decryption rotates right after it
	localparam int SHIFT_ENC = SHIFT_SCHEDULE[ROUND_IDX];
	localparam int SHIFT_DEC = SHIFT_SCHEDULE[NUM_ROUNDS + 1 - ROUND_IDX];

	function automatic logic [KEY_HALF_W-1:0] rotLeft(
		input logic [KEY_HALF_W-1:0] x,
		input int                    n
	);
		return (x << n) | (x >> (KEY_HALF_W - n));
	endfunction

	function automatic logic [KEY_HALF_W-1:0] rotRight(
		input logic [KEY_HALF_W-1:0] x,
		input int                    n
	);
		return (x >> n) | (x << (KEY_HALF_W - n));
	endfunction

	function automatic logic [SUBKEY_W-1:0] pc2Perm(input logic [2*KEY_HALF_W-1:0] x);
		return {x[42], x[39], x[45], x[32], x[55], x[51],
				x[53], x[28], x[41], x[50], x[35], x[46],
				x[33], x[37], x[44], x[52], x[30], x[48],
				x[40], x[49], x[29], x[36], x[43], x[54],
				x[15], x[ 4], x[25], x[19], x[ 9], x[ 1],
				x[26], x[16], x[ 5], x[11], x[23], x[ 8],
				x[12], x[ 7], x[17], x[ 0], x[22], x[ 3],
				x[10], x[14], x[ 6], x[20], x[27], x[24]};
	endfunction

	// E table, each 4-bit group borrows its neighbours' edge bits
	function automatic logic [SUBKEY_W-1:0] expand(input logic [HALF_W-1:0] x);
		return {x[0], x[31:27], x[28:23], x[24:19], x[20:15],
				x[16:11], x[12:7], x[8:3], x[4:0], x[31]};
	endfunction

	function automatic logic [HALF_W-1:0] pPerm(input logic [HALF_W-1:0] x);
		return {x[16], x[25], x[12], x[11], x[ 3], x[20], x[ 4], x[15],
				x[31], x[17], x[ 9], x[ 6], x[27], x[14], x[ 1], x[22],
				x[30], x[24], x[ 8], x[18], x[ 0], x[ 5], x[29], x[23],
				x[13], x[19], x[ 2], x[26], x[10], x[21], x[28], x[ 7]};
	endfunction

	logic [KEY_HALF_W-1:0] cKey;
	logic [KEY_HALF_W-1:0] dKey;
	logic [KEY_HALF_W-1:0] cNext;
	logic [KEY_HALF_W-1:0] dNext;
	logic [SUBKEY_W-1:0]   subKey;
	logic [SUBKEY_W-1:0]   sboxIn;
	logic [HALF_W-1:0]     sboxOut;
	logic [HALF_W-1:0]     roundOut;
	roundState_t           nextState;

	// ##############################
	// key schedule step
	// ##############################
	always_comb begin
		if (i_State.mode == MODE_DEC) begin
			cKey  = i_State.c;
			dKey  = i_State.d;
			cNext = rotRight(i_State.c, SHIFT_DEC);
			dNext = rotRight(i_State.d, SHIFT_DEC);
		end else begin
			cKey  = rotLeft(i_State.c, SHIFT_ENC);
			dKey  = rotLeft(i_State.d, SHIFT_ENC);
			cNext = cKey;
			dNext = dKey;
		end
	end

	assign subKey = pc2Perm({cKey, dKey});

	// ##############################
	// round function
	// ##############################
	assign sboxIn = expand(i_State.r) ^ subKey;

	// S1 sits in the top six bits
	always_comb begin
		for (int b = 0; b < 8; b++) begin
			sboxOut[HALF_W-1-4*b -: 4] = sboxLookup(3'(b), sboxIn[SUBKEY_W-1-6*b -: 6]);
		end
	end

	assign roundOut = pPerm(sboxOut);

	// valid and mode ride along untouched
	always_comb begin
		nextState   = i_State;
		nextState.l = i_State.r;
		nextState.r = i_State.l ^ roundOut;
		nextState.c = cNext;
		nextState.d = dNext;
	end

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			o_State <= '0;
		end else begin
			o_State <= nextState;
		end
	end

	// an idle slot arrives with its key halves cleared
	idleSlotNoKey: assert property (
		@(posedge i_Clk) disable iff (!i_Rst)
		!i_State.valid |-> (i_State.c == '0 && i_State.d == '0)
	);

endmodule

`default_nettype wire

/* desInputStage.sv */
`default_nettype none
`timescale 1ns/100ps

module desInputStage (
	input  wire                         i_Clk,
	input  wire                         i_Rst,
	input  wire                         i_fStart,
	input  wire                         i_fDec,
	input  wire [desPkg::BLOCK_W-1:0]   i_Key,
	input  wire [desPkg::BLOCK_W-1:0]   i_Text,
	output desPkg::roundState_t         o_State
);
	import desPkg::*;

	// initial permutation
	function automatic logic [BLOCK_W-1:0] ipPerm(input logic [BLOCK_W-1:0] x);
		return {x[ 6], x[14], x[22], x[30], x[38], x[46], x[54], x[62],
				x[ 4], x[12], x[20], x[28], x[36], x[44], x[52], x[60],
				x[ 2], x[10], x[18], x[26], x[34], x[42], x[50], x[58],
				x[ 0], x[ 8], x[16], x[24], x[32], x[40], x[48], x[56],
				x[ 7], x[15], x[23], x[31], x[39], x[47], x[55], x[63],
				x[ 5], x[13], x[21], x[29], x[37], x[45], x[53], x[61],
				x[ 3], x[11], x[19], x[27], x[35], x[43], x[51], x[59],
				x[ 1], x[ 9], x[17], x[25], x[33], x[41], x[49], x[57]};
	endfunction

	// PC1 drops the parity bits, C in the upper half
	function automatic logic [2*KEY_HALF_W-1:0] pc1Perm(input logic [BLOCK_W-1:0] x);
		return {x[ 7], x[15], x[23], x[31], x[39], x[47], x[55],
				x[63], x[ 6], x[14], x[22], x[30], x[38], x[46],
				x[54], x[62], x[ 5], x[13], x[21], x[29], x[37],
				x[45], x[53], x[61], x[ 4], x[12], x[20], x[28],
				x[ 1], x[ 9], x[17], x[25], x[33], x[41], x[49],
				x[57], x[ 2], x[10], x[18], x[26], x[34], x[42],
				x[50], x[58], x[ 3], x[11], x[19], x[27], x[35],
				x[43], x[51], x[59], x[36], x[44], x[52], x[60]};
	endfunction

	logic [BLOCK_W-1:0]      ipText;
	logic [2*KEY_HALF_W-1:0] pc1Key;
	roundState_t             nextState;

	assign ipText = ipPerm(i_Text);
	assign pc1Key = pc1Perm(i_Key);

	// idle slots stay all zero so no key bits linger in the pipe
	always_comb begin
		nextState = '0;
		if (i_fStart) begin
			nextState.valid = 1'b1;
			nextState.mode  = i_fDec ? MODE_DEC : MODE_ENC;
			nextState.l     = ipText[BLOCK_W-1:HALF_W];
			nextState.r     = ipText[HALF_W-1:0];
			nextState.c     = pc1Key[2*KEY_HALF_W-1:KEY_HALF_W];
			nextState.d     = pc1Key[KEY_HALF_W-1:0];
		end
	end

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			o_State <= '0;
		end else begin
			o_State <= nextState;
		end
	end

endmodule

`default_nettype wire

/* desPkg.sv */
`default_nettype none

package desPkg;

	// ##############################
	// widths
	// ##############################
	localparam int BLOCK_W    = 64;
	localparam int HALF_W     = 32;
	localparam int KEY_HALF_W = 28;
	localparam int SUBKEY_W   = 48;
	localparam int NUM_ROUNDS = 16;

	typedef enum logic {
		MODE_ENC = 1'b0,
		MODE_DEC = 1'b1
	} desMode_t;

	// one pipeline slot, text halves and key halves travel together
	typedef struct packed {
		logic                  valid;
		desMode_t              mode;
		logic [HALF_W-1:0]     l;
		logic [HALF_W-1:0]     r;
		logic [KEY_HALF_W-1:0] c;
		logic [KEY_HALF_W-1:0] d;
	} roundState_t;

	// left rotation per encryption round, index 1 is the first round
	localparam int SHIFT_SCHEDULE [1:NUM_ROUNDS] = '{
		1, 1, 2, 2, 2, 2, 2, 2,
		1, 2, 2, 2, 2, 2, 2, 1
	};

	`include "desSboxTables.svh"

	// ##############################
	// s-box access
	// ##############################
	// outer bits pick the row, inner four the column
	function automatic logic [3:0] sboxLookup(
		input logic [2:0] box,
		input logic [5:0] sixBits
	);
		logic [1:0] row;
		logic [3:0] col;
		row = {sixBits[5], sixBits[0]};
		col = sixBits[4:1];
		return SBOX_TABLE[box][{row, col}];
	endfunction

endpackage

`default_nettype wire

/* desSboxTables.svh */
`ifndef DES_SBOX_TABLES_SVH
`define DES_SBOX_TABLES_SVH

// ##############################
// s-boxes S1..S8
// ##############################
// indexed [box][row * 16 + column], one table row per line
localparam logic [3:0] SBOX_TABLE [0:7][0:63] = '{
	// S1
	'{
		14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
	},
	// S2
	'{
		15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
	},
	// S3
	'{
		10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
	},
	// S4
	'{
		 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
	},
	// S5
	'{
		 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
	},
	// S6
	'{
		12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
	},
	// S7
	'{
		 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
	},
	// S8
	'{
		13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
	}
};

`endif
